//--- list.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_regfile.sv
hdl/csr_writeback.sv
hdl/csr_unit.sv
tb/csr_props.sv
tb/csr_checker.sv
tb/csr_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module csr_tb -f list.f -o csr_sim
out=$(./obj_dir/csr_sim || true)
echo "$out"
if echo "$out" | grep -q "^PASS: all tests$"; then
	exit 0
fi
exit 1

//--- tb/csr_tb.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_tb;

	logic		clock;
	logic		rst_n;
	logic		in_valid;
	logic [31:0]	inst;
	logic [31:0]	rs1_data;
	logic [31:0]	pc;
	logic		rd_we;
	logic [4:0]	rd_addr;
	logic [31:0]	rd_data;
	logic		redirect;
	logic [31:0]	redirect_pc;

	integer		seed;
	logic [31:0]	next_pc;
	logic [11:0]	rw_list [0:3];
	logic [11:0]	ro_list [0:2];
	int		issued = 0;
	int		err_mark = 0;
	int		timeouts = 0;
	int		pass_count = 0;
	int		fail_count = 0;

	csr_unit u_dut (
		.clock(clock), .rst_n(rst_n), .in_valid(in_valid), .inst(inst),
		.rs1_data(rs1_data), .pc(pc), .rd_we(rd_we), .rd_addr(rd_addr),
		.rd_data(rd_data), .redirect(redirect), .redirect_pc(redirect_pc)
	);

	csr_checker u_check (
		.clock(clock), .rst_n(rst_n), .in_valid(in_valid), .inst(inst),
		.rs1_data(rs1_data), .pc(pc), .rd_we(rd_we), .rd_addr(rd_addr),
		.rd_data(rd_data), .redirect(redirect), .redirect_pc(redirect_pc)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] csr_word(input logic [2:0] f3, input logic [11:0] addr,
			input logic [4:0] src, input logic [4:0] dst);
		return {addr, src, f3, dst, `OPC_SYSTEM};
	endfunction

	task automatic issue(input logic [31:0] word, input logic [31:0] src_val);
		@(negedge clock);
		in_valid = 1'b1;
		inst = word;
		rs1_data = src_val;
		pc = next_pc;
		next_pc = next_pc + 32'd4;
		issued++;
	endtask

	// Plain read, set form with x0 as source.
	task automatic read_csr(input logic [11:0] addr);
		issue(csr_word(`F3_CSRRS, addr, 5'd0, 5'd5), $random(seed));
	endtask

	task automatic finish_test(input string name);
		int waited;
		int errs;
		waited = 0;
		@(negedge clock);
		in_valid = 1'b0;
		while (u_check.checked_count != issued && waited < 10) begin
			@(posedge clock);
			waited++;
		end
		errs = u_check.err_count - err_mark;
		if (u_check.checked_count != issued) begin
			$display("%s: pipeline did not drain, outputs missing", name);
			timeouts++;
			errs++;
		end
		err_mark = u_check.err_count;
		if (errs == 0) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: %0d errors", name, errs);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		seed = 32'h704a4ce7;
		rst_n = 1'b0;
		in_valid = 1'b0;
		inst = 32'd0;
		rs1_data = 32'd0;
		pc = 32'd0;
		next_pc = 32'h0000_1000;
		rw_list = '{`CSR_ADDR_MTVEC, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MSTATUS};
		ro_list = '{`CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, 12'h7c0};
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		foreach (rw_list[i]) read_csr(rw_list[i]);
		read_csr(`CSR_ADDR_MVENDORID);
		read_csr(`CSR_ADDR_MARCHID);
		finish_test("reset_values");

		foreach (rw_list[i]) begin
			issue(csr_word(`F3_CSRRW, rw_list[i], 5'd1, 5'd2), $random(seed));
			issue(csr_word(`F3_CSRRS, rw_list[i], 5'd3, 5'd4), $random(seed));
			issue(csr_word(`F3_CSRRC, rw_list[i], 5'd6, 5'd7), $random(seed));
			// A zero source field must not write, whatever rs1_data holds.
			issue(csr_word(`F3_CSRRS, rw_list[i], 5'd0, 5'd8), $random(seed));
			issue(csr_word(`F3_CSRRC, rw_list[i], 5'd0, 5'd9), $random(seed));
			r = $random(seed);
			issue(csr_word(`F3_CSRRWI, rw_list[i], r[4:0], 5'd10), 32'd0);
			issue(csr_word(`F3_CSRRSI, rw_list[i], r[9:5], 5'd11), 32'd0);
			issue(csr_word(`F3_CSRRCI, rw_list[i], r[14:10], 5'd12), 32'd0);
			issue(csr_word(`F3_CSRRSI, rw_list[i], 5'd0, 5'd13), 32'd0);
			read_csr(rw_list[i]);
		end
		finish_test("csr_ops");

		foreach (ro_list[i]) begin
			issue(csr_word(`F3_CSRRW, ro_list[i], 5'd1, 5'd11), $random(seed));
			issue(csr_word(`F3_CSRRS, ro_list[i], 5'd2, 5'd12), $random(seed));
			read_csr(ro_list[i]);
		end
		finish_test("read_only");

		issue(csr_word(`F3_CSRRW, `CSR_ADDR_MTVEC, 5'd1, 5'd0), $random(seed));
		issue(csr_word(`F3_CSRRSI, `CSR_ADDR_MSTATUS, 5'd8, 5'd0), 32'd0);
		r = $random(seed);
		next_pc = {r[31:2], 2'b00};
		issue(32'h0000_0073, 32'd0);
		read_csr(`CSR_ADDR_MEPC);
		read_csr(`CSR_ADDR_MCAUSE);
		read_csr(`CSR_ADDR_MSTATUS);
		finish_test("ecall");

		issue(csr_word(`F3_CSRRW, `CSR_ADDR_MEPC, 5'd1, 5'd0), $random(seed));
		issue(32'h3020_0073, 32'd0);
		read_csr(`CSR_ADDR_MSTATUS);
		finish_test("mret");

		r = $random(seed);
		r2 = $random(seed);
		issue(csr_word(`F3_CSRRW, `CSR_ADDR_MCAUSE, 5'd1, 5'd1), r);
		issue(csr_word(`F3_CSRRS, `CSR_ADDR_MCAUSE, 5'd2, 5'd2), r2);
		issue(csr_word(`F3_CSRRC, `CSR_ADDR_MCAUSE, 5'd3, 5'd3), r);
		issue(csr_word(`F3_CSRRWI, `CSR_ADDR_MTVEC, 5'd21, 5'd4), 32'd0);
		issue(32'h0000_0013, r2);
		issue(32'h0000_0073, 32'd0);
		read_csr(`CSR_ADDR_MEPC);
		issue(32'h3020_0073, 32'd0);
		read_csr(`CSR_ADDR_MSTATUS);
		finish_test("back_to_back");

		$display("Tests passed %0d, failed %0d, errors %0d", pass_count, fail_count,
				u_check.err_count + timeouts);
		if (fail_count == 0 && u_check.err_count == 0 && timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- tb/csr_checker.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_checker (
	input  logic		clock,
	input  logic		rst_n,
	input  logic		in_valid,
	input  logic [31:0]	inst,
	input  logic [31:0]	rs1_data,
	input  logic [31:0]	pc,
	input  logic		rd_we,
	input  logic [4:0]	rd_addr,
	input  logic [31:0]	rd_data,
	input  logic		redirect,
	input  logic [31:0]	redirect_pc
);

	typedef struct packed {
		logic		valid;
		logic [31:0]	inst;
		logic [31:0]	rs1_data;
		logic [31:0]	pc;
	} slot_t;

	typedef struct packed {
		logic		rd_we;
		logic [4:0]	rd;
		logic [31:0]	rd_data;
		logic		redirect;
		logic [31:0]	redirect_pc;
	} expect_t;

	// Model of the CSR state, kept in program order.
	logic		m_mie;
	logic		m_mpie;
	logic [31:0]	m_mtvec;
	logic [31:0]	m_mepc;
	logic [31:0]	m_mcause;
	slot_t		hist0;
	slot_t		hist1;
	logic		armed = 1'b0;
	int		err_count = 0;
	int		checked_count = 0;

	function automatic logic [31:0] model_read(input logic [11:0] addr);
		case (addr)
			`CSR_ADDR_MSTATUS: return `MSTATUS_RESET | ({31'd0, m_mie} << 3) |
					({31'd0, m_mpie} << 7);
			`CSR_ADDR_MTVEC: return m_mtvec;
			`CSR_ADDR_MEPC: return m_mepc;
			`CSR_ADDR_MCAUSE: return m_mcause;
			`CSR_ADDR_MVENDORID: return `MVENDORID_VAL;
			`CSR_ADDR_MARCHID: return `MARCHID_VAL;
			default: return 32'd0;
		endcase
	endfunction

	// Read-only and unknown addresses drop the write.
	function automatic void model_write(input logic [11:0] addr, input logic [31:0] val);
		case (addr)
			`CSR_ADDR_MSTATUS: begin
				m_mie = val[3];
				m_mpie = val[7];
			end
			`CSR_ADDR_MTVEC: m_mtvec = val;
			`CSR_ADDR_MEPC: m_mepc = {val[31:2], 2'b00};
			`CSR_ADDR_MCAUSE: m_mcause = val;
			default: ;
		endcase
	endfunction

	function automatic expect_t ref_model(input logic [31:0] word, input logic [31:0] src,
			input logic [31:0] at_pc);
		expect_t	e;
		logic [31:0]	old;
		logic [31:0]	opnd;
		logic [11:0]	addr;
		logic [4:0]	rs1;
		logic [2:0]	f3;
		e = '0;
		addr = word[31:20];
		rs1 = word[19:15];
		f3 = word[14:12];
		if (word[6:0] != `OPC_SYSTEM || f3 == 3'b100) begin
			return e;
		end
		if (f3 == `F3_PRIV) begin
			if (word[31:25] == `F7_ECALL && word[24:20] == `RS2_ECALL) begin
				e.redirect = 1'b1;
				e.redirect_pc = {m_mtvec[31:2], 2'b00};
				// Instructions are word aligned, so mepc drops the low bits.
				m_mepc = {at_pc[31:2], 2'b00};
				m_mcause = `CAUSE_ECALL_M;
				m_mpie = m_mie;
				m_mie = 1'b0;
			end else if (word[31:25] == `F7_MRET && word[24:20] == `RS2_MRET) begin
				e.redirect = 1'b1;
				e.redirect_pc = m_mepc;
				m_mie = m_mpie;
				m_mpie = 1'b1;
			end
			return e;
		end
		old = model_read(addr);
		opnd = f3[2] ? {27'd0, rs1} : src;
		e.rd_we = (word[11:7] != 5'd0);
		e.rd = word[11:7];
		e.rd_data = old;
		case (f3[1:0])
			2'b01: model_write(addr, opnd);
			2'b10: if (rs1 != 5'd0) model_write(addr, old | opnd);
			default: if (rs1 != 5'd0) model_write(addr, old & ~opnd);
		endcase
		return e;
	endfunction

	task automatic compare(input string name, input logic [31:0] exp_v, input logic [31:0] act);
		if (exp_v !== act) begin
			$display("Mismatch %s: expected %h, got %h at %0t", name, exp_v, act, $time);
			err_count++;
		end
	endtask

	// Two-deep input history lines up with the two-edge latency.
	always @(posedge clock) begin
		armed <= rst_n;
		hist1 <= hist0;
		hist0 <= {in_valid && rst_n, inst, rs1_data, pc};
		if (!rst_n) begin
			hist1.valid <= 1'b0;
		end
	end

	always @(negedge clock) begin
		expect_t exp_s;
		exp_s = '0;
		if (!armed) begin
			m_mie = 1'b0;
			m_mpie = 1'b0;
			m_mtvec = 32'd0;
			m_mepc = 32'd0;
			m_mcause = 32'd0;
		end else begin
			if (hist1.valid) begin
				exp_s = ref_model(hist1.inst, hist1.rs1_data, hist1.pc);
				checked_count++;
			end
			compare("rd_we", {31'd0, exp_s.rd_we}, {31'd0, rd_we});
			compare("redirect", {31'd0, exp_s.redirect}, {31'd0, redirect});
			if (exp_s.rd_we) begin
				compare("rd_addr", {27'd0, exp_s.rd}, {27'd0, rd_addr});
				compare("rd_data", exp_s.rd_data, rd_data);
			end
			if (exp_s.redirect) begin
				compare("redirect_pc", exp_s.redirect_pc, redirect_pc);
			end
		end
	end

endmodule

//--- tb/csr_props.sv
`timescale 1ns/1ps

module csr_props (
	input  logic		clock,
	input  logic		rst_n,
	input  logic		rd_we,
	input  logic		redirect,
	input  logic [31:0]	redirect_pc
);

	// Quiet through reset and for one cycle after release.
	quiet_after_reset: assert property (@(posedge clock)
		(!rst_n || $rose(rst_n)) |=> (!rd_we && !redirect))
		else $error("rd_we or redirect high during or just after reset");

	writeback_or_redirect: assert property (@(posedge clock) disable iff (!rst_n)
		!(rd_we && redirect))
		else $error("rd_we and redirect high in the same cycle");

	redirect_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		redirect |-> (redirect_pc[1:0] == 2'b00))
		else $error("redirect_pc not word aligned");

endmodule

bind csr_unit csr_props u_props (
	.clock(clock), .rst_n(rst_n), .rd_we(rd_we), .redirect(redirect),
	.redirect_pc(redirect_pc)
);

//--- hdl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
	input  logic		clock,
	input  logic		rst_n,
	input  logic		in_valid,
	input  csr_inst_u	inst,
	input  logic [31:0]	rs1_data,
	input  logic [31:0]	pc,
	output logic		rd_we,
	output logic [4:0]	rd_addr,
	output logic [31:0]	rd_data,
	output logic		redirect,
	output logic [31:0]	redirect_pc
);

	csr_req_t	req;
	csr_resp_t	resp;

	// Stage 1, registered request.
	csr_decode u_decode (
		.clock		(clock),
		.rst_n		(rst_n),
		.in_valid	(in_valid),
		.inst		(inst),
		.rs1_data	(rs1_data),
		.pc		(pc),
		.req		(req)
	);

	// Stage 2, CSR access and trap state.
	csr_regfile u_regfile (
		.clock	(clock),
		.rst_n	(rst_n),
		.req	(req),
		.resp	(resp)
	);

	csr_writeback u_writeback (
		.clock		(clock),
		.rst_n		(rst_n),
		.resp		(resp),
		.rd_we		(rd_we),
		.rd_addr	(rd_addr),
		.rd_data	(rd_data),
		.redirect	(redirect),
		.redirect_pc	(redirect_pc)
	);

endmodule

//--- hdl/csr_writeback.sv
`timescale 1ns/1ps

module csr_writeback import csr_pkg::*; (
	input  logic		clock,
	input  logic		rst_n,
	input  csr_resp_t	resp,
	output logic		rd_we,
	output logic [4:0]	rd_addr,
	output logic [31:0]	rd_data,
	output logic		redirect,
	output logic [31:0]	redirect_pc
);

	// Enables, gated by the slot valid.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rd_we <= 1'b0;
			redirect <= 1'b0;
		end else begin
			rd_we <= resp.valid && resp.rd_we;
			redirect <= resp.valid && resp.redirect;
		end
	end

	// Data fields keep their last value between valid slots.
	always_ff @(posedge clock) begin
		if (resp.valid) begin
			rd_addr <= resp.rd;
			rd_data <= resp.old_val;
			redirect_pc <= resp.redirect_pc;
		end
	end

endmodule

//--- hdl/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_regfile import csr_pkg::*; (
	input  logic		clock,
	input  logic		rst_n,
	input  csr_req_t	req,
	output csr_resp_t	resp
);

	// Only MIE and MPIE of mstatus hold state.
	logic		mstatus_mie;
	logic		mstatus_mpie;
	logic [31:0]	mtvec;
	logic [31:0]	mepc;
	logic [31:0]	mcause;

	logic [31:0]	mstatus_val;
	logic [31:0]	old_val;
	logic [31:0]	new_val;
	logic		is_csr_op;
	logic		is_ecall;
	logic		is_mret;
	logic		wr_en;

	always_comb begin
		mstatus_val = `MSTATUS_RESET;
		mstatus_val[`MSTATUS_MIE_BIT] = mstatus_mie;
		mstatus_val[`MSTATUS_MPIE_BIT] = mstatus_mpie;
	end

	// Read side. Unknown addresses read as zero.
	always_comb begin
		case (req.addr)
			`CSR_ADDR_MSTATUS:	old_val = mstatus_val;
			`CSR_ADDR_MTVEC:	old_val = mtvec;
			`CSR_ADDR_MEPC:		old_val = mepc;
			`CSR_ADDR_MCAUSE:	old_val = mcause;
			`CSR_ADDR_MVENDORID:	old_val = `MVENDORID_VAL;
			`CSR_ADDR_MARCHID:	old_val = `MARCHID_VAL;
			default:		old_val = 32'd0;
		endcase
	end

	always_comb begin
		case (req.op)
			CSR_OP_WRITE:	new_val = req.operand;
			CSR_OP_SET:	new_val = old_val | req.operand;
			CSR_OP_CLEAR:	new_val = old_val & ~req.operand;
			default:	new_val = old_val;
		endcase
	end

	assign is_csr_op = (req.op == CSR_OP_WRITE) || (req.op == CSR_OP_SET) ||
			(req.op == CSR_OP_CLEAR);
	assign is_ecall = req.valid && (req.op == CSR_OP_ECALL);
	assign is_mret = req.valid && (req.op == CSR_OP_MRET);
	assign wr_en = req.valid && is_csr_op && !req.no_write;

	// State update. Writes to read-only or unknown addresses fall through.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
			mtvec <= 32'd0;
			mepc <= 32'd0;
			mcause <= 32'd0;
		end else if (is_ecall) begin
			mepc <= {req.pc[31:2], 2'b00};
			mcause <= `CAUSE_ECALL_M;
			mstatus_mpie <= mstatus_mie;
			mstatus_mie <= 1'b0;
		end else if (is_mret) begin
			mstatus_mie <= mstatus_mpie;
			mstatus_mpie <= 1'b1;
		end else if (wr_en) begin
			case (req.addr)
				`CSR_ADDR_MSTATUS: begin
					mstatus_mie <= new_val[`MSTATUS_MIE_BIT];
					mstatus_mpie <= new_val[`MSTATUS_MPIE_BIT];
				end
				`CSR_ADDR_MTVEC: begin
					mtvec <= new_val;
				end
				`CSR_ADDR_MEPC: begin
					// No compressed instructions, so mepc stays word aligned.
					mepc <= {new_val[31:2], 2'b00};
				end
				`CSR_ADDR_MCAUSE: begin
					mcause <= new_val;
				end
				default: begin
					mcause <= mcause;
				end
			endcase
		end
	end

	// Response to writeback.
	always_comb begin
		resp.valid = req.valid;
		resp.rd_we = req.valid && is_csr_op && (req.rd != 5'd0);
		resp.rd = req.rd;
		resp.old_val = old_val;
		resp.redirect = is_ecall || is_mret;
		// Direct mode, so the trap target ignores the mode bits.
		if (is_ecall) begin
			resp.redirect_pc = {mtvec[31:2], 2'b00};
		end else begin
			resp.redirect_pc = mepc;
		end
	end

endmodule

//--- hdl/csr_decode.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_decode import csr_pkg::*; (
	input  logic		clock,
	input  logic		rst_n,
	input  logic		in_valid,
	input  csr_inst_u	inst,
	input  logic [31:0]	rs1_data,
	input  logic [31:0]	pc,
	output csr_req_t	req
);

	csr_req_t	req_d;
	logic		is_system;
	logic		src_zero;
	logic [31:0]	zimm;

	assign is_system = (inst.csr.opcode == `OPC_SYSTEM);
	// Same field is x0 for register forms and a zero uimm for immediate forms.
	assign src_zero = (inst.csr.rs1 == 5'd0);
	assign zimm = {27'd0, inst.csr.rs1};

	always_comb begin
		req_d.valid = in_valid;
		req_d.op = CSR_OP_NONE;
		req_d.addr = inst.csr.csr;
		req_d.rd = inst.csr.rd;
		req_d.operand = rs1_data;
		req_d.no_write = 1'b0;
		req_d.pc = pc;
		if (is_system) begin
			case (inst.csr.funct3)
				`F3_CSRRW: begin
					req_d.op = CSR_OP_WRITE;
				end
				`F3_CSRRS: begin
					req_d.op = CSR_OP_SET;
					req_d.no_write = src_zero;
				end
				`F3_CSRRC: begin
					req_d.op = CSR_OP_CLEAR;
					req_d.no_write = src_zero;
				end
				`F3_CSRRWI: begin
					req_d.op = CSR_OP_WRITE;
					req_d.operand = zimm;
				end
				`F3_CSRRSI: begin
					req_d.op = CSR_OP_SET;
					req_d.operand = zimm;
					req_d.no_write = src_zero;
				end
				`F3_CSRRCI: begin
					req_d.op = CSR_OP_CLEAR;
					req_d.operand = zimm;
					req_d.no_write = src_zero;
				end
				`F3_PRIV: begin
					// ECALL and MRET share funct3, split on funct7 and rs2.
					if (inst.priv.funct7 == `F7_ECALL && inst.priv.rs2 == `RS2_ECALL) begin
						req_d.op = CSR_OP_ECALL;
					end else if (inst.priv.funct7 == `F7_MRET &&
							inst.priv.rs2 == `RS2_MRET) begin
						req_d.op = CSR_OP_MRET;
					end
				end
				default: begin
					req_d.op = CSR_OP_NONE;
				end
			endcase
		end
	end

	// Only the valid bit needs clearing, the rest is qualified by it.
	always_ff @(posedge clock) begin
		req <= req_d;
		if (!rst_n) begin
			req.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/csr_pkg.sv
package csr_pkg;

	// CSR-form view of an instruction word.
	typedef struct packed {
		logic [11:0]	csr;
		logic [4:0]	rs1;
		logic [2:0]	funct3;
		logic [4:0]	rd;
		logic [6:0]	opcode;
	} csr_inst_csr_t;

	// PRIV-form view, used for ECALL and MRET.
	typedef struct packed {
		logic [6:0]	funct7;
		logic [4:0]	rs2;
		logic [4:0]	rs1;
		logic [2:0]	funct3;
		logic [4:0]	rd;
		logic [6:0]	opcode;
	} csr_inst_priv_t;

	// Top twelve bits are either a CSR address or funct7/rs2.
	typedef union packed {
		csr_inst_csr_t	csr;
		csr_inst_priv_t	priv;
	} csr_inst_u;

	typedef enum logic [2:0] {
		CSR_OP_NONE	= 3'd0,
		CSR_OP_WRITE	= 3'd1,
		CSR_OP_SET	= 3'd2,
		CSR_OP_CLEAR	= 3'd3,
		CSR_OP_ECALL	= 3'd4,
		CSR_OP_MRET	= 3'd5
	} csr_op_e;

	// Decode to regfile.
	typedef struct packed {
		logic		valid;
		csr_op_e	op;
		logic [11:0]	addr;
		logic [4:0]	rd;
		// rs1 data or zero-extended immediate.
		logic [31:0]	operand;
		// Set or clear with a zero source field.
		logic		no_write;
		logic [31:0]	pc;
	} csr_req_t;

	// Regfile to writeback.
	typedef struct packed {
		logic		valid;
		logic		rd_we;
		logic [4:0]	rd;
		logic [31:0]	old_val;
		logic		redirect;
		logic [31:0]	redirect_pc;
	} csr_resp_t;

endpackage

//--- hdl/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Machine-mode CSR addresses.
`define CSR_ADDR_MSTATUS	12'h300
`define CSR_ADDR_MTVEC		12'h305
`define CSR_ADDR_MEPC		12'h341
`define CSR_ADDR_MCAUSE		12'h342
`define CSR_ADDR_MVENDORID	12'hf11
`define CSR_ADDR_MARCHID	12'hf12

// SYSTEM opcode and funct3 encodings.
`define OPC_SYSTEM	7'b1110011
`define F3_PRIV		3'b000
`define F3_CSRRW	3'b001
`define F3_CSRRS	3'b010
`define F3_CSRRC	3'b011
`define F3_CSRRWI	3'b101
`define F3_CSRRSI	3'b110
`define F3_CSRRCI	3'b111

// PRIV group, told apart by funct7 and rs2.
`define F7_ECALL	7'b0000000
`define RS2_ECALL	5'd0
`define F7_MRET		7'b0011000
`define RS2_MRET	5'd2

`define CAUSE_ECALL_M	32'd11

`define MVENDORID_VAL	32'h0000_0a5a
`define MARCHID_VAL	32'h0000_0019
// MPP fixed at machine mode, MIE and MPIE clear.
`define MSTATUS_RESET	32'h0000_1800
`define MSTATUS_MIE_BIT		3
`define MSTATUS_MPIE_BIT	7

`endif
